// ==== common/rvIsaPkg.sv ====
package rvIsaPkg;

   // major opcodes of the supported subset
   typedef enum logic [6:0] {
      opImm    = 7'b0010011,
      opBranch = 7'b1100011
   } opcodeT;

   // funct3 selects the operation inside an opcode group
   typedef enum logic [2:0] {
      f3Addi = 3'b000,
      f3Bne  = 3'b001
   } funct3T;

   // instruction field positions
   localparam int opLsb     = 0;
   localparam int opMsb     = 6;
   localparam int rdLsb     = 7;
   localparam int rdMsb     = 11;
   localparam int funct3Lsb = 12;
   localparam int funct3Msb = 14;
   localparam int rs1Lsb    = 15;
   localparam int rs1Msb    = 19;
   localparam int rs2Lsb    = 20;
   localparam int rs2Msb    = 24;

endpackage

// ==== common/cpuCfgPkg.sv ====
package cpuCfgPkg;

   // datapath word width
   localparam int dataWidth = 32;
   typedef logic [dataWidth-1:0] dataWordT;

   // register file geometry
   localparam int numRegs      = 32;
   localparam int regAddrWidth = $clog2(numRegs);
   typedef logic [regAddrWidth-1:0] regAddrT;

   // register index of a0 (x10)
   localparam int a0Index = 10;

   // instruction memory depth in words
   localparam int imemDepth     = 64;
   localparam int imemAddrWidth = $clog2(imemDepth);
   typedef logic [imemAddrWidth-1:0] imemAddrT;

   // sequential step of the program counter in bytes
   localparam int pcStep = 4;

   // immediate format select of the decoder
   typedef enum logic [1:0] {
      immI = 2'b00,
      immB = 2'b10
   } immSrcT;

   typedef enum logic {
      aluAdd = 1'b0,
      aluSub = 1'b1
   } aluCtrlT;

endpackage

// ==== decode/controlUnit.sv ====
module controlUnit
   import rvIsaPkg::*, cpuCfgPkg::*;
(
   input  dataWordT instr,
   input  logic     eq,
   output aluCtrlT  aluCtrl,
   output logic     aluSrc,
   output immSrcT   immSrc,
   output logic     pcSrc,
   output logic     regWrite
);

   opcodeT op;
   funct3T funct3;

   assign op     = opcodeT'(instr[opMsb:opLsb]);
   assign funct3 = funct3T'(instr[funct3Msb:funct3Lsb]);

   always_comb begin
      // safe defaults, nothing written and no branch
      aluCtrl  = aluAdd;
      aluSrc   = 1'b0;
      immSrc   = immB;
      pcSrc    = 1'b0;
      regWrite = 1'b0;

      case (op)
         opImm: begin
            immSrc = immI;
            aluSrc = 1'b1;
            case (funct3)
               f3Addi: begin
                  regWrite = 1'b1;
               end
               default: begin
                  // other I-type ALU ops retire as no-ops
                  regWrite = 1'b0;
               end
            endcase
         end

         opBranch: begin
            immSrc = immB;
            case (funct3)
               f3Bne: begin
                  aluSrc  = 1'b0;
                  aluCtrl = aluSub;
                  // taken only when the operands differ
                  pcSrc   = ~eq;
               end
               default: begin
                  aluSrc = 1'b1;
                  pcSrc  = 1'b0;
               end
            endcase
         end

         default: begin
            // unknown opcode, all write and branch controls low
            aluSrc = 1'b0;
         end
      endcase
   end

endmodule

// ==== decode/immExtend.sv ====
module immExtend
   import cpuCfgPkg::*;
(
   input  dataWordT instr,
   input  immSrcT   immSrc,
   output dataWordT imm
);

   dataWordT immIType;
   dataWordT immBType;

   // I-type, imm[11:0] in bits 31:20
   assign immIType = {{(dataWidth-12){instr[31]}}, instr[31:20]};

   // B-type, imm[12|10:5|4:1|11] scattered, bit 0 always zero
   assign immBType = {{(dataWidth-13){instr[31]}},
                      instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};

   always_comb begin
      case (immSrc)
         immI:    imm = immIType;
         immB:    imm = immBType;
         default: imm = immIType;
      endcase
   end

endmodule

// ==== execute/regFile.sv ====
module regFile
   import cpuCfgPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     we,
   input  regAddrT  ra1,
   input  regAddrT  ra2,
   input  regAddrT  wa,
   input  dataWordT wd,
   output dataWordT rd1,
   output dataWordT rd2,
   output dataWordT a0
);

   dataWordT regs [numRegs];

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < numRegs; i++) begin
            regs[i] <= '0;
         end
      end else if (we && (wa != '0)) begin
         // x0 is hardwired, so its writes are dropped
         regs[wa] <= wd;
      end
   end

   // combinational read ports
   assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
   assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

   // observation port for a0
   assign a0 = regs[a0Index];

endmodule

// ==== execute/alu.sv ====
module alu
   import cpuCfgPkg::*;
(
   input  dataWordT srcA,
   input  dataWordT srcB,
   input  aluCtrlT  aluCtrl,
   output dataWordT sum,
   output logic     eq
);

   always_comb begin
      case (aluCtrl)
         aluAdd:  sum = srcA + srcB;
         aluSub:  sum = srcA - srcB;
         default: sum = srcA + srcB;
      endcase
   end

   // equality flag feeds the bne decision
   assign eq = (srcA == srcB);

endmodule

// ==== result/pcUnit.sv ====
module pcUnit
   import cpuCfgPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     run,
   input  logic     pcSrc,
   input  dataWordT imm,
   output dataWordT pc
);

   dataWordT pcPlus4;
   dataWordT pcTarget;
   dataWordT nextPc;

   assign pcPlus4  = pc + dataWordT'(pcStep);
   assign pcTarget = pc + imm;

   // branch target wins when the branch is taken
   assign nextPc = pcSrc ? pcTarget : pcPlus4;

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         pc <= '0;
      end else if (run) begin
         pc <= nextPc;
      end
   end

endmodule

// ==== logic/instrMem.sv ====
module instrMem
   import cpuCfgPkg::*;
(
   input  logic     clk,
   input  logic     we,
   input  imemAddrT wAddr,
   input  dataWordT wData,
   input  imemAddrT rAddr,
   output dataWordT rData
);

   dataWordT mem [imemDepth];

   // program load port, contents survive a core reset
   always_ff @(posedge clk) begin
      if (we) begin
         mem[wAddr] <= wData;
      end
   end

   // asynchronous fetch
   assign rData = mem[rAddr];

endmodule

// ==== logic/cpuTop.sv ====
module cpuTop
   import rvIsaPkg::*, cpuCfgPkg::*;
(
   input  logic     clk,
   input  logic     rstN,
   input  logic     run,
   input  logic     progWe,
   input  imemAddrT progAddr,
   input  dataWordT progData,
   output dataWordT pc,
   output dataWordT a0
);

   dataWordT instr;
   dataWordT imm;
   dataWordT rd1;
   dataWordT rd2;
   dataWordT srcB;
   dataWordT sum;
   imemAddrT fetchAddr;
   regAddrT  rs1;
   regAddrT  rs2;
   regAddrT  rd;
   aluCtrlT  aluCtrl;
   immSrcT   immSrc;
   logic     aluSrc;
   logic     pcSrc;
   logic     regWrite;
   logic     regWe;
   logic     memWe;
   logic     eq;

   // word index of the fetch address
   assign fetchAddr = pc[imemAddrWidth+1:2];

   // memory is only loaded while the core is halted
   assign memWe = progWe & ~run;

   instrMem i_instrMem (
      .clk   (clk),
      .we    (memWe),
      .wAddr (progAddr),
      .wData (progData),
      .rAddr (fetchAddr),
      .rData (instr)
   );

   assign rs1 = instr[rs1Msb:rs1Lsb];
   assign rs2 = instr[rs2Msb:rs2Lsb];
   assign rd  = instr[rdMsb:rdLsb];

   controlUnit i_controlUnit (
      .instr    (instr),
      .eq       (eq),
      .aluCtrl  (aluCtrl),
      .aluSrc   (aluSrc),
      .immSrc   (immSrc),
      .pcSrc    (pcSrc),
      .regWrite (regWrite)
   );

   immExtend i_immExtend (
      .instr  (instr),
      .immSrc (immSrc),
      .imm    (imm)
   );

   // registers change only on edges that retire an instruction
   assign regWe = regWrite & run;

   regFile i_regFile (
      .clk  (clk),
      .rstN (rstN),
      .we   (regWe),
      .ra1  (rs1),
      .ra2  (rs2),
      .wa   (rd),
      .wd   (sum),
      .rd1  (rd1),
      .rd2  (rd2),
      .a0   (a0)
   );

   // second operand is the immediate for addi, rs2 for bne
   assign srcB = aluSrc ? imm : rd2;

   alu i_alu (
      .srcA    (rd1),
      .srcB    (srcB),
      .aluCtrl (aluCtrl),
      .sum     (sum),
      .eq      (eq)
   );

   pcUnit i_pcUnit (
      .clk   (clk),
      .rstN  (rstN),
      .run   (run),
      .pcSrc (pcSrc),
      .imm   (imm),
      .pc    (pc)
   );

endmodule

// ==== dv/cpuTop_properties.sv ====
module cpuTopProperties
   import cpuCfgPkg::*;
(
   input logic     clk,
   input logic     rstN,
   input logic     run,
   input dataWordT pc
);
   timeunit 1ns;
   timeprecision 1ps;

   int failCount = 0;

   // fetch is word addressed so the low pc bits never move
   pcAligned: assert property (@(posedge clk) disable iff (!rstN) pc[1:0] == 2'b00)
      else begin
         $error("pc is not word aligned: %h", pc);
         failCount++;
      end

   pcHoldsWhenHalted: assert property (@(posedge clk) disable iff (!rstN)
      !run |=> $stable(pc))
      else begin
         $error("pc moved while run was low");
         failCount++;
      end

   pcZeroAfterReset: assert property (@(posedge clk) $rose(rstN) |-> pc == '0)
      else begin
         $error("pc is not zero after reset release: %h", pc);
         failCount++;
      end

endmodule

bind cpuTop cpuTopProperties i_cpuTopProperties (
   .clk  (clk),
   .rstN (rstN),
   .run  (run),
   .pc   (pc)
);

// ==== dv/cpuTb.sv ====
module cpuTb
   import rvIsaPkg::*, cpuCfgPkg::*;
();
   timeunit 1ns;
   timeprecision 1ps;

   localparam int clkPeriod   = 8;
   localparam int resetCycles = 10;
   // six tests of under 80 cycles each including load and reset
   localparam int cycleLimit  = 2000;
   localparam regAddrT zeroReg = 5'd0;
   localparam regAddrT t1Reg   = 5'd6;
   localparam regAddrT a0Reg   = regAddrT'(a0Index);

   logic     clk;
   logic     rstN;
   logic     run;
   logic     progWe;
   imemAddrT progAddr;
   dataWordT progData;
   dataWordT pc;
   dataWordT a0;

   logic [31:0] rngState = 32'd37151;
   int          cycleCount = 0;
   dataWordT    progWords[$];
   dataWordT    chainWords[$];
   int          chainLen;
   dataWordT    chainSum;

   cpuTop i_cpuTop (
      .clk      (clk),
      .rstN     (rstN),
      .run      (run),
      .progWe   (progWe),
      .progAddr (progAddr),
      .progData (progData),
      .pc       (pc),
      .a0       (a0)
   );

   initial begin
      clk = 1'b0;
      forever #(clkPeriod / 2) clk = ~clk;
   end

   always @(posedge clk) cycleCount <= cycleCount + 1;

   initial begin
      wait (cycleCount >= cycleLimit);
      $display("timeout: the tests did not finish within %0d cycles", cycleLimit);
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the cycle limit");
   end

   // the bound checker counts its assertion failures
   initial begin
      wait (i_cpuTop.i_cpuTopProperties.failCount != 0);
      $display("an assertion on the cpuTop ports failed");
      $display("TEST FAILED");
      $fatal(1, "simulation stopped at the first assertion failure");
   end

   function automatic logic [31:0] nextRandom();
      rngState ^= rngState << 13;
      rngState ^= rngState >> 17;
      rngState ^= rngState << 5;
      return rngState;
   endfunction

   // random signed 12-bit immediate
   function automatic int randImm();
      logic [31:0] r;
      r = nextRandom();
      return int'($signed(r[11:0]));
   endfunction

   function automatic dataWordT iTypeWord(logic [6:0] op, logic [2:0] f3, regAddrT rd,
                                          regAddrT rs1, int imm);
      return {imm[11:0], rs1, f3, rd, op};
   endfunction

   function automatic dataWordT addiWord(regAddrT rd, regAddrT rs1, int imm);
      return iTypeWord(opImm, f3Addi, rd, rs1, imm);
   endfunction

   function automatic dataWordT branchWord(logic [2:0] f3, regAddrT rs1, regAddrT rs2,
                                           int offset);
      return {offset[12], offset[10:5], rs2, rs1, f3, offset[4:1], offset[11], opBranch};
   endfunction

   task automatic loadProgram();
      foreach (progWords[i]) begin
         @(posedge clk);
         progWe   <= 1'b1;
         progAddr <= imemAddrT'(i);
         progData <= progWords[i];
      end
      @(posedge clk);
      progWe <= 1'b0;
   endtask

   task automatic pulseReset();
      @(posedge clk);
      rstN <= 1'b0;
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
   endtask

   // n edges with run high and a sample on the falling edge after them
   task automatic runCycles(int n);
      @(posedge clk);
      run <= 1'b1;
      repeat (n) @(posedge clk);
      run <= 1'b0;
      @(negedge clk);
   endtask

   task automatic comparePc(string testName, dataWordT expected, dataWordT actual);
      if (actual !== expected) begin
         $display("Fail %s: pc expected %h, actual %h", testName, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "pc mismatch");
      end
   endtask

   task automatic compareA0(string testName, dataWordT expected, dataWordT actual);
      if (actual !== expected) begin
         $display("Fail %s: a0 expected %h, actual %h", testName, expected, actual);
         $display("TEST FAILED");
         $fatal(1, "a0 mismatch");
      end
   endtask

   task automatic addiChain();
      int n;
      int k;
      n = 4 + int'(nextRandom() % 5);
      chainSum = '0;
      progWords.delete();
      for (int i = 0; i < n; i++) begin
         k = randImm();
         // make sure at least one immediate is negative
         if (i == 1 && k >= 0) k = -k - 1;
         chainSum += dataWordT'(k);
         progWords.push_back(addiWord(a0Reg, (i == 0) ? zeroReg : a0Reg, k));
      end
      chainLen = n;
      chainWords = progWords;
      loadProgram();
      pulseReset();
      runCycles(n);
      compareA0("addiChain", chainSum, a0);
      comparePc("addiChain", dataWordT'(4 * n), pc);
   endtask

   task automatic countingLoop();
      int target;
      int loopCycles;
      target = 3 + int'(nextRandom() % 20);
      progWords.delete();
      progWords.push_back(addiWord(t1Reg, zeroReg, target));
      progWords.push_back(addiWord(a0Reg, zeroReg, 0));
      progWords.push_back(addiWord(a0Reg, a0Reg, 1));
      progWords.push_back(branchWord(f3Bne, a0Reg, t1Reg, -4));
      // two setup instructions and one addi plus one bne per pass
      loopCycles = 2 + 2 * target;
      loadProgram();
      pulseReset();
      runCycles(loopCycles);
      compareA0("countingLoop", dataWordT'(target), a0);
      // every taken bne goes back 4 instead of forward 4
      comparePc("countingLoop", dataWordT'(4 * loopCycles - 8 * (target - 1)), pc);
   endtask

   task automatic bneFallThrough();
      int k;
      k = randImm();
      progWords.delete();
      progWords.push_back(addiWord(a0Reg, zeroReg, k));
      progWords.push_back(branchWord(f3Bne, a0Reg, a0Reg, 8));
      progWords.push_back(addiWord(a0Reg, a0Reg, 1));
      loadProgram();
      pulseReset();
      runCycles(3);
      compareA0("bneFallThrough", dataWordT'(k + 1), a0);
      comparePc("bneFallThrough", dataWordT'(12), pc);
   endtask

   task automatic unsupportedNops();
      int k;
      k = randImm();
      progWords.delete();
      progWords.push_back(addiWord(a0Reg, zeroReg, k));
      progWords.push_back(iTypeWord(opImm, 3'b010, a0Reg, zeroReg, 99));
      // unknown opcode shaped like an addi to a0
      progWords.push_back(iTypeWord(7'b1111111, 3'b000, a0Reg, zeroReg, 55));
      progWords.push_back(branchWord(3'b000, zeroReg, zeroReg, -8));
      loadProgram();
      pulseReset();
      runCycles(1);
      for (int i = 1; i <= 3; i++) begin
         runCycles(1);
         compareA0("unsupportedNops", dataWordT'(k), a0);
         comparePc("unsupportedNops", dataWordT'(4 * (i + 1)), pc);
      end
   endtask

   task automatic x0Discard();
      progWords.delete();
      progWords.push_back(addiWord(zeroReg, zeroReg, 5));
      progWords.push_back(addiWord(a0Reg, zeroReg, 0));
      loadProgram();
      pulseReset();
      runCycles(2);
      compareA0("x0Discard", '0, a0);
      comparePc("x0Discard", dataWordT'(8), pc);
   endtask

   task automatic midRunReset();
      int part;
      progWords = chainWords;
      loadProgram();
      pulseReset();
      part = 1 + int'(nextRandom() % (chainLen - 1));
      @(posedge clk);
      run <= 1'b1;
      repeat (part) @(posedge clk);
      rstN <= 1'b0;
      @(negedge clk);
      comparePc("midRunReset", '0, pc);
      compareA0("midRunReset", '0, a0);
      @(posedge clk);
      run <= 1'b0;
      repeat (resetCycles - 1) @(posedge clk);
      rstN <= 1'b1;
      runCycles(chainLen);
      compareA0("midRunReset", chainSum, a0);
      comparePc("midRunReset", dataWordT'(4 * chainLen), pc);
   endtask

   initial begin
      rstN     = 1'b0;
      run      = 1'b0;
      progWe   = 1'b0;
      progAddr = '0;
      progData = '0;
      repeat (resetCycles) @(posedge clk);
      rstN <= 1'b1;
      addiChain();
      countingLoop();
      bneFallThrough();
      unsupportedNops();
      x0Discard();
      midRunReset();
      $display("TEST OK");
      $finish;
   end

endmodule

// ==== vlog.f ====
common/rvIsaPkg.sv
common/cpuCfgPkg.sv
decode/controlUnit.sv
decode/immExtend.sv
execute/regFile.sv
execute/alu.sv
result/pcUnit.sv
logic/instrMem.sv
logic/cpuTop.sv
dv/cpuTop_properties.sv
dv/cpuTb.sv
